/* Makefile */
TOP = decodeTb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	! grep -q ">>> FAIL" sim.log
	grep -q ">>> PASS" sim.log

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* filelist.f */
hdl/decodePkg.sv
hdl/immGen.sv
hdl/ctrlDecode.sv
hdl/regScoreboard.sv
hdl/decodeStage.sv
hdl/decodeTop.sv
test/decodeTop_chk.sv
test/decodeTb.sv

/* hdl/ctrlDecode.sv */
`default_nettype none

module ctrlDecode import decodePkg::*; (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    output immFmtT     immFmt,
    output aluOpT      aluOp,
    output logic       wordOp,
    output logic       aluSrcA,
    output aluSrcBT    aluSrcB,
    output branchT     branch,
    output logic       memRd,
    output logic       memWr,
    output logic [2:0] memOp,
    output logic       regWr,
    output logic       isCsr,
    output logic       useRs1,
    output logic       useRs2,
    output logic       decErr
);
    opcodeT major;
    logic   badOp;

    function automatic aluOpT aluFromF3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? aluSub : aluAdd;
            3'b001:  return aluSll;
            3'b010:  return aluSlt;
            3'b011:  return aluSltu;
            3'b100:  return aluXor;
            3'b101:  return alt ? aluSra : aluSrl;
            3'b110:  return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    assign major = opcodeT'(opcode[6:2]);
    assign memOp = funct3;      // size and sign for loads and stores

    always_comb begin
        immFmt  = fmtI;
        aluOp   = aluAdd;
        wordOp  = 1'b0;
        aluSrcA = 1'b0;         // 1 selects pc
        aluSrcB = srcBImm;
        branch  = brNone;
        memRd   = 1'b0;
        memWr   = 1'b0;
        regWr   = 1'b0;
        isCsr   = 1'b0;
        badOp   = 1'b0;
        case (major)
            opLoad: begin
                memRd = 1'b1;
                regWr = 1'b1;
                badOp = (funct3 == 3'b111);
            end
            opStore: begin
                immFmt = fmtS;
                memWr  = 1'b1;
                badOp  = funct3[2];
            end
            opOpImm: begin
                regWr = 1'b1;
                aluOp = aluFromF3(funct3, funct3 == 3'b101 && funct7[5]);
                if (funct3 == 3'b001)
                    badOp = (funct7[6:1] != 6'b000000);     // shamt[5] lives in funct7[0]
                else if (funct3 == 3'b101)
                    badOp = (funct7[6:1] != 6'b000000) && (funct7[6:1] != 6'b010000);
            end
            opOpImm32: begin
                regWr  = 1'b1;
                wordOp = 1'b1;
                aluOp  = aluFromF3(funct3, funct3 == 3'b101 && funct7[5]);
                badOp  = !((funct3 == 3'b000) ||
                           (funct3 == 3'b001 && funct7 == 7'b0000000) ||
                           (funct3 == 3'b101 && (funct7 == 7'b0000000 ||
                                                 funct7 == 7'b0100000)));
            end
            opOp, opOp32: begin
                immFmt  = fmtNone;
                aluSrcB = srcBReg;
                regWr   = 1'b1;
                wordOp  = (major == opOp32);
                case (funct7)
                    7'b0000000: begin
                        aluOp = aluFromF3(funct3, 1'b0);
                        badOp = wordOp && !(funct3 == 3'b000 || funct3 == 3'b001 ||
                                            funct3 == 3'b101);
                    end
                    7'b0100000: begin
                        aluOp = aluFromF3(funct3, 1'b1);
                        badOp = (funct3 != 3'b000) && (funct3 != 3'b101);    // sub, sra only
                    end
                    7'b0000001: begin
                        aluOp = aluMul;
                        badOp = wordOp && (funct3 == 3'b001 || funct3 == 3'b010 ||
                                           funct3 == 3'b011);
                    end
                    default: begin
                        badOp = 1'b1;
                    end
                endcase
            end
            opLui: begin
                immFmt = fmtU;
                aluOp  = aluPassB;
                regWr  = 1'b1;
            end
            opAuipc: begin
                immFmt  = fmtU;
                aluSrcA = 1'b1;
                regWr   = 1'b1;
            end
            opJal: begin
                immFmt  = fmtJ;
                aluSrcA = 1'b1;
                aluSrcB = srcBFour;
                branch  = brJal;
                regWr   = 1'b1;
            end
            opJalr: begin
                aluSrcA = 1'b1;
                aluSrcB = srcBFour;
                branch  = brJalr;
                regWr   = 1'b1;
                badOp   = (funct3 != 3'b000);
            end
            opBranch: begin
                immFmt  = fmtB;
                aluSrcB = srcBReg;
                case (funct3)
                    3'b000: begin
                        branch = brEq;
                        aluOp  = aluSub;
                    end
                    3'b001: begin
                        branch = brNe;
                        aluOp  = aluSub;
                    end
                    3'b100: begin
                        branch = brLt;
                        aluOp  = aluSlt;
                    end
                    3'b101: begin
                        branch = brGe;
                        aluOp  = aluSlt;
                    end
                    3'b110: begin
                        branch = brLtu;
                        aluOp  = aluSltu;
                    end
                    3'b111: begin
                        branch = brGeu;
                        aluOp  = aluSltu;
                    end
                    default: begin
                        badOp = 1'b1;
                    end
                endcase
            end
            opSystem: begin
                isCsr = 1'b1;
                aluOp = aluPassB;
                regWr = 1'b1;
                badOp = (funct3 == 3'b100);
            end
            default: begin
                immFmt = fmtNone;
                badOp  = 1'b1;
            end
        endcase
    end

    assign decErr = badOp || (opcode[1:0] != 2'b11);

    // operand usage follows the format
    always_comb begin
        case (immFmt)
            fmtI: begin
                useRs1 = !decErr;
                useRs2 = 1'b0;
            end
            fmtS, fmtB, fmtNone: begin
                useRs1 = !decErr;
                useRs2 = !decErr;
            end
            default: begin
                useRs1 = 1'b0;
                useRs2 = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/decodePkg.sv */
`default_nettype none

package decodePkg;

    typedef enum logic [4:0] {
        opLoad    = 5'b00000,
        opOpImm   = 5'b00100,
        opAuipc   = 5'b00101,
        opOpImm32 = 5'b00110,
        opStore   = 5'b01000,
        opOp      = 5'b01100,
        opLui     = 5'b01101,
        opOp32    = 5'b01110,
        opBranch  = 5'b11000,
        opJalr    = 5'b11001,
        opJal     = 5'b11011,
        opSystem  = 5'b11100
    } opcodeT;

    typedef enum logic [2:0] {
        fmtI,
        fmtS,
        fmtB,
        fmtU,
        fmtJ,
        fmtNone     // R-type, no immediate
    } immFmtT;

    typedef enum logic [4:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
        aluSrl, aluSra, aluOr, aluAnd, aluPassB,
        aluMul      // whole M group, not executed here
    } aluOpT;

    // nine kinds need four bits
    typedef enum logic [3:0] {
        brNone, brJal, brJalr, brEq, brNe, brLt, brGe, brLtu, brGeu
    } branchT;

    typedef enum logic [2:0] {
        sysNone, sysEcall, sysEbreak, sysMret, sysCsr
    } sysOpT;

    typedef enum logic [1:0] {
        srcBReg,
        srcBImm,
        srcBFour    // link address for jumps
    } aluSrcBT;

    typedef logic [4:0] regIdxT;

    localparam logic [31:0] instrEcall  = 32'h0000_0073;
    localparam logic [31:0] instrEbreak = 32'h0010_0073;
    localparam logic [31:0] instrMret   = 32'h3020_0073;

endpackage

`default_nettype wire

/* hdl/decodeStage.sv */
`default_nettype none

module decodeStage import decodePkg::*; #(
    parameter int pcWidth = 64
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               inVld,
    input  logic [31:0]        instr,
    input  logic [pcWidth-1:0] pc,
    input  logic               fetchErr,
    input  logic               flush,
    input  logic               rs1Busy,
    input  logic               rs2Busy,
    output logic               outVld,
    output logic               issueVld,
    output logic [pcWidth-1:0] pcOut,
    output regIdxT             rd,
    output regIdxT             rs1,
    output regIdxT             rs2,
    output logic [31:0]        imm,
    output aluOpT              aluOp,
    output logic               wordOp,
    output logic               aluSrcA,
    output aluSrcBT            aluSrcB,
    output branchT             branch,
    output logic               memRd,
    output logic               memWr,
    output logic [2:0]         memOp,
    output logic               regWr,
    output sysOpT              sysOp,
    output logic [11:0]        csrAddr,
    output logic               illegal,
    output logic               rsBlock
);
    logic               vldQ;
    logic [31:0]        instrQ;
    logic [pcWidth-1:0] pcQ;
    logic               fetchErrQ;
    logic               accept;
    immFmtT             immFmt;
    logic               memRdDec;
    logic               memWrDec;
    logic               regWrDec;
    logic               isCsr;
    logic               useRs1;
    logic               useRs2;
    logic               decErr;

    assign accept = inVld && !rsBlock;

    always_ff @(posedge clk) begin
        if (rst || flush)
            vldQ <= 1'b0;
        else if (accept)
            vldQ <= 1'b1;
        else if (!rsBlock)
            vldQ <= 1'b0;           // issued, slot empties
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instrQ    <= instr;
            pcQ       <= pc;
            fetchErrQ <= fetchErr;
        end
    end

    ctrlDecode ctrl (
        .opcode  (instrQ[6:0]),
        .funct3  (instrQ[14:12]),
        .funct7  (instrQ[31:25]),
        .immFmt  (immFmt),
        .aluOp   (aluOp),
        .wordOp  (wordOp),
        .aluSrcA (aluSrcA),
        .aluSrcB (aluSrcB),
        .branch  (branch),
        .memRd   (memRdDec),
        .memWr   (memWrDec),
        .memOp   (memOp),
        .regWr   (regWrDec),
        .isCsr   (isCsr),
        .useRs1  (useRs1),
        .useRs2  (useRs2),
        .decErr  (decErr)
    );

    immGen immUnit (
        .instr  (instrQ[31:7]),
        .immFmt (immFmt),
        .imm    (imm)
    );

    always_comb begin
        sysOp = sysNone;
        if (isCsr) begin
            if (instrQ[14:12] != 3'b000)
                sysOp = sysCsr;
            else if (instrQ == instrEcall)
                sysOp = sysEcall;
            else if (instrQ == instrEbreak)
                sysOp = sysEbreak;
            else if (instrQ == instrMret)
                sysOp = sysMret;
        end
    end

    // funct3 zero system word that matched none of the three
    assign illegal = decErr || fetchErrQ ||
                     (isCsr && instrQ[14:12] == 3'b000 && sysOp == sysNone);

    assign regWr = regWrDec && !illegal;
    assign memRd = memRdDec && !illegal;
    assign memWr = memWrDec && !illegal;

    assign rsBlock  = vldQ && ((useRs1 && rs1Busy) || (useRs2 && rs2Busy));
    assign outVld   = vldQ && !rsBlock && !flush;
    assign issueVld = outVld && regWr;      // marks rd pending

    assign pcOut   = pcQ;
    assign rd      = instrQ[11:7];
    assign rs1     = instrQ[19:15];
    assign rs2     = instrQ[24:20];
    assign csrAddr = instrQ[31:20];

endmodule

`default_nettype wire

/* hdl/decodeTop.sv */
`default_nettype none

module decodeTop #(
    parameter int pcWidth = 64
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               inVld,
    input  logic [31:0]        instr,
    input  logic [pcWidth-1:0] pc,
    input  logic               fetchErr,
    input  logic               flush,
    input  logic               wbVld,
    input  logic [4:0]         wbRd,
    output logic               outVld,
    output logic [pcWidth-1:0] pcOut,
    output logic [4:0]         rd,
    output logic [4:0]         rs1,
    output logic [4:0]         rs2,
    output logic [31:0]        imm,
    output logic [4:0]         aluOp,
    output logic               wordOp,
    output logic               aluSrcA,
    output logic [1:0]         aluSrcB,
    output logic [3:0]         branch,
    output logic               memRd,
    output logic               memWr,
    output logic [2:0]         memOp,
    output logic               regWr,
    output logic [2:0]         sysOp,
    output logic [11:0]        csrAddr,
    output logic               illegal,
    output logic               rsBlock
);
    logic issueVld;
    logic rs1Busy;
    logic rs2Busy;

    decodeStage #(
        .pcWidth (pcWidth)
    ) stage (
        .clk      (clk),
        .rst      (rst),
        .inVld    (inVld),
        .instr    (instr),
        .pc       (pc),
        .fetchErr (fetchErr),
        .flush    (flush),
        .rs1Busy  (rs1Busy),
        .rs2Busy  (rs2Busy),
        .outVld   (outVld),
        .issueVld (issueVld),
        .pcOut    (pcOut),
        .rd       (rd),
        .rs1      (rs1),
        .rs2      (rs2),
        .imm      (imm),
        .aluOp    (aluOp),
        .wordOp   (wordOp),
        .aluSrcA  (aluSrcA),
        .aluSrcB  (aluSrcB),
        .branch   (branch),
        .memRd    (memRd),
        .memWr    (memWr),
        .memOp    (memOp),
        .regWr    (regWr),
        .sysOp    (sysOp),
        .csrAddr  (csrAddr),
        .illegal  (illegal),
        .rsBlock  (rsBlock)
    );

    regScoreboard scoreboard (
        .clk      (clk),
        .rst      (rst),
        .issueVld (issueVld),
        .issueRd  (rd),
        .wbVld    (wbVld),
        .wbRd     (wbRd),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1Busy  (rs1Busy),
        .rs2Busy  (rs2Busy)
    );

endmodule

`default_nettype wire

/* hdl/immGen.sv */
`default_nettype none

module immGen import decodePkg::*; (
    input  logic [31:7] instr,
    input  immFmtT      immFmt,
    output logic [31:0] imm
);

    always_comb begin
        case (immFmt)
            fmtI: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            fmtS: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            fmtB: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};          // halfword aligned
            end
            fmtU: begin
                imm = {instr[31:12], 12'b0};
            end
            fmtJ: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                imm = 32'b0;                        // R-type
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/regScoreboard.sv */
`default_nettype none

module regScoreboard import decodePkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   issueVld,
    input  regIdxT issueRd,
    input  logic   wbVld,
    input  regIdxT wbRd,
    input  regIdxT rs1,
    input  regIdxT rs2,
    output logic   rs1Busy,
    output logic   rs2Busy
);
    logic [31:1] pending;
    logic [31:0] busyVec;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            for (int i = 1; i < 32; i++) begin
                if (issueVld && issueRd == regIdxT'(i))
                    pending[i] <= 1'b1;     // issue beats same-edge writeback
                else if (wbVld && wbRd == regIdxT'(i))
                    pending[i] <= 1'b0;
            end
        end
    end

    assign busyVec = {pending, 1'b0};       // x0 never busy
    assign rs1Busy = busyVec[rs1];
    assign rs2Busy = busyVec[rs2];

endmodule

`default_nettype wire

/* test/decodeTb.sv */
`default_nettype none

module decodeTb import decodePkg::*; ();

    localparam int pcWidth = 64;

    typedef struct packed {
        logic [31:0] imm;
        aluOpT       aluOp;
        logic        wordOp;
        logic        aluSrcA;
        aluSrcBT     aluSrcB;
        branchT      branch;
        logic        memRd;
        logic        memWr;
        logic [2:0]  memOp;
        logic        regWr;
        sysOpT       sysOp;
        logic        illegal;
    } expT;

    logic               clk;
    logic               rst;
    logic               inVld;
    logic [31:0]        instr;
    logic [pcWidth-1:0] pc;
    logic               fetchErr;
    logic               flush;
    logic               wbVld;
    logic [4:0]         wbRd;
    logic               outVld;
    logic [pcWidth-1:0] pcOut;
    logic [4:0]         rd;
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic [31:0]        imm;
    logic [4:0]         aluOp;
    logic               wordOp;
    logic               aluSrcA;
    logic [1:0]         aluSrcB;
    logic [3:0]         branch;
    logic               memRd;
    logic               memWr;
    logic [2:0]         memOp;
    logic               regWr;
    logic [2:0]         sysOp;
    logic [11:0]        csrAddr;
    logic               illegal;
    logic               rsBlock;

    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;
    logic [31:0] rngState = 32'h8716a28e;

    aluOpT  baseAlu [8] = '{aluAdd, aluSll, aluSlt, aluSltu, aluXor, aluSrl, aluOr, aluAnd};
    branchT brKinds [8] = '{brEq, brNe, brNone, brNone, brLt, brGe, brLtu, brGeu};
    opcodeT majors [12] = '{opLoad, opOpImm, opAuipc, opOpImm32, opStore, opOp,
                            opLui, opOp32, opBranch, opJalr, opJal, opSystem};
    logic [6:0] f7Set [3] = '{7'h00, 7'h20, 7'h01};
    logic [31:0] badWords [6] = '{
        {12'h008, 5'd1, 3'b111, 5'd2, 7'b0000011},          // load, funct3 7
        {7'h00, 5'd3, 5'd1, 3'b100, 5'd4, 7'b0100011},      // store, funct3 4
        {7'h00, 5'd3, 5'd1, 3'b010, 5'd8, 7'b1100011},      // branch, funct3 2
        {7'h40, 5'd3, 5'd1, 3'b000, 5'd2, 7'b0110011},      // R-type, funct7 40
        {12'h001, 5'd0, 3'b000, 5'd1, 7'b0010001},          // low opcode bits 01
        32'h1050_0073                                       // wfi, not supported
    };

    decodeTop #(
        .pcWidth (pcWidth)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    // expected fields straight from the RV64I/M encoding rules
    function automatic expT refDecode(input logic [31:0] w, input logic fErr);
        expT        e;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       bad;
        logic       op32;
        f3 = w[14:12];
        f7 = w[31:25];
        bad = 1'b0;
        op32 = (w[6:2] == opOp32);
        e = '0;
        e.aluSrcB = srcBImm;
        e.memOp = f3;
        case (w[6:2])
            opLoad: begin
                e.imm = 32'($signed(w[31:20]));
                e.memRd = 1'b1;
                e.regWr = 1'b1;
                bad = (f3 == 3'd7);
            end
            opStore: begin
                e.imm = 32'($signed({w[31:25], w[11:7]}));
                e.memWr = 1'b1;
                bad = (f3 > 3'd3);
            end
            opOpImm, opOpImm32: begin
                e.imm = 32'($signed(w[31:20]));
                e.regWr = 1'b1;
                e.aluOp = baseAlu[f3];
                if (f3 == 3'd5 && f7[5])
                    e.aluOp = aluSra;
                if (w[6:2] == opOpImm32) begin
                    e.wordOp = 1'b1;
                    bad = !(f3 == 3'd0 || (f3 == 3'd1 && f7 == 7'h00) ||
                            (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20)));
                end else if (f3 == 3'd1) begin
                    bad = (f7[6:1] != 6'h00);          // f7[0] is shamt bit 5
                end else if (f3 == 3'd5) begin
                    bad = (f7[6:1] != 6'h00) && (f7[6:1] != 6'h10);
                end
            end
            opOp, opOp32: begin
                e.aluSrcB = srcBReg;
                e.regWr = 1'b1;
                e.wordOp = op32;
                if (f7 == 7'h00) begin
                    e.aluOp = baseAlu[f3];
                    bad = op32 && !(f3 inside {3'd0, 3'd1, 3'd5});
                end else if (f7 == 7'h20) begin
                    e.aluOp = (f3 == 3'd0) ? aluSub : aluSra;
                    bad = !(f3 inside {3'd0, 3'd5});
                end else if (f7 == 7'h01) begin
                    e.aluOp = aluMul;
                    bad = op32 && (f3 inside {3'd1, 3'd2, 3'd3});
                end else begin
                    bad = 1'b1;
                end
            end
            opLui: begin
                e.imm = {w[31:12], 12'h000};
                e.aluOp = aluPassB;
                e.regWr = 1'b1;
            end
            opAuipc: begin
                e.imm = {w[31:12], 12'h000};
                e.aluSrcA = 1'b1;
                e.regWr = 1'b1;
            end
            opJal: begin
                e.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
                e.aluSrcA = 1'b1;
                e.aluSrcB = srcBFour;
                e.branch = brJal;
                e.regWr = 1'b1;
            end
            opJalr: begin
                e.imm = 32'($signed(w[31:20]));
                e.aluSrcA = 1'b1;
                e.aluSrcB = srcBFour;
                e.branch = brJalr;
                e.regWr = 1'b1;
                bad = (f3 != 3'd0);
            end
            opBranch: begin
                e.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
                e.aluSrcB = srcBReg;
                e.branch = brKinds[f3];
                e.aluOp = !f3[2] ? aluSub : (f3[1] ? aluSltu : aluSlt);
                bad = (f3 == 3'd2 || f3 == 3'd3);
            end
            opSystem: begin
                e.imm = 32'($signed(w[31:20]));
                e.aluOp = aluPassB;
                e.regWr = 1'b1;
                bad = (f3 == 3'd4);
                if (f3 != 3'd0)
                    e.sysOp = sysCsr;
                else if (w == 32'h0000_0073)
                    e.sysOp = sysEcall;
                else if (w == 32'h0010_0073)
                    e.sysOp = sysEbreak;
                else if (w == 32'h3020_0073)
                    e.sysOp = sysMret;
                else
                    bad = 1'b1;
            end
            default: begin
                bad = 1'b1;
            end
        endcase
        e.illegal = bad || (w[1:0] != 2'b11) || fErr;
        if (e.illegal) begin
            e.regWr = 1'b0;
            e.memRd = 1'b0;
            e.memWr = 1'b0;
        end
        return e;
    endfunction

    task automatic compareField(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %0h, expected %0h, instr %08h", name, got, exp, instr);
        end
    endtask

    task automatic checkFields(input expT e, input logic [31:0] w);
        compareField("illegal", illegal, e.illegal);
        compareField("regWr", regWr, e.regWr);
        compareField("memRd", memRd, e.memRd);
        compareField("memWr", memWr, e.memWr);
        compareField("rd", rd, w[11:7]);
        compareField("rs1", rs1, w[19:15]);
        compareField("rs2", rs2, w[24:20]);
        compareField("csrAddr", csrAddr, w[31:20]);
        compareField("pcOut", pcOut, pc);
        if (!e.illegal) begin                       // other fields are don't care
            compareField("imm", imm, e.imm);
            compareField("aluOp", aluOp, e.aluOp);
            compareField("wordOp", wordOp, e.wordOp);
            compareField("aluSrcA", aluSrcA, e.aluSrcA);
            compareField("aluSrcB", aluSrcB, e.aluSrcB);
            compareField("branch", branch, e.branch);
            compareField("memOp", memOp, e.memOp);
            compareField("sysOp", sysOp, e.sysOp);
        end
    endtask

    task automatic sendStrobe(input logic [31:0] w, input logic fErr);
        @(posedge clk);
        #1;
        inVld = 1'b1;
        instr = w;
        fetchErr = fErr;
        pc = pc + 64'd4;
        @(posedge clk);                             // captured here
        #1;
        inVld = 1'b0;
        fetchErr = 1'b0;
    endtask

    task automatic waitOutVld(output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < 10) begin
            @(negedge clk);
            seen = outVld;
            n++;
        end
        if (!seen) begin
            timeouts++;
            $display("Timeout: no outVld within 10 cycles for instr %08h", instr);
        end
    endtask

    task automatic retireReg(input logic [4:0] r);
        @(posedge clk);
        #1;
        wbVld = 1'b1;
        wbRd = r;
        @(posedge clk);
        #1;
        wbVld = 1'b0;
    endtask

    task automatic runDecode(input logic [31:0] w, input logic fErr);
        expT e;
        bit  seen;
        e = refDecode(w, fErr);
        sendStrobe(w, fErr);
        waitOutVld(seen);
        if (seen) begin
            checkFields(e, w);
            if (regWr && rd != 5'd0)
                retireReg(rd);                      // keep scoreboard empty
        end
    endtask

    task automatic immediateCases();
        logic [31:0] w;
        int          k;
        int          n;
        for (k = 0; k < 5; k++) begin
            for (n = 0; n < 6; n++) begin
                w = nextRand();
                w[31] = n[0];                       // both signs per format
                case (k)
                    0: begin
                        w[6:0] = 7'b0010011;        // addi
                        w[14:12] = 3'b000;
                    end
                    1: begin
                        w[6:0] = 7'b0100011;        // sd
                        w[14:12] = 3'b011;
                    end
                    2: begin
                        w[6:0] = 7'b1100011;        // beq
                        w[14:12] = 3'b000;
                    end
                    3: w[6:0] = 7'b0110111;         // lui
                    default: w[6:0] = 7'b1101111;   // jal
                endcase
                runDecode(w, 1'b0);
            end
        end
    endtask

    task automatic controlSweep();
        logic [31:0] r;
        logic [31:0] w;
        int          k;
        int          f3;
        int          j;
        for (k = 0; k < 12; k++) begin
            for (f3 = 0; f3 < 8; f3++) begin
                for (j = 0; j < 3; j++) begin
                    r = nextRand();
                    w = {f7Set[j], r[24:15], 3'(f3), r[11:7], majors[k], 2'b11};
                    runDecode(w, 1'b0);
                end
            end
        end
    endtask

    task automatic illegalCases();
        int n;
        for (n = 0; n < 6; n++) begin
            runDecode(badWords[n], 1'b0);
            compareField("illegal", illegal, 1);
        end
        runDecode(32'h0010_0093, 1'b1);             // addi x1, x0, 1 with fetch error
        compareField("illegal", illegal, 1);
    endtask

    task automatic stallCase();
        logic [31:0] producer;
        logic [31:0] consumer;
        bit          seen;
        int          n;
        producer = {7'h00, 5'd2, 5'd1, 3'b000, 5'd5, 7'b0110011};      // add x5, x1, x2
        consumer = {7'h00, 5'd3, 5'd5, 3'b000, 5'd6, 7'b0110011};      // add x6, x5, x3
        sendStrobe(producer, 1'b0);
        waitOutVld(seen);
        if (seen)
            checkFields(refDecode(producer, 1'b0), producer);
        sendStrobe(consumer, 1'b0);
        for (n = 0; n < 5; n++) begin
            @(negedge clk);
            compareField("rsBlock", rsBlock, 1);
            compareField("outVld", outVld, 0);
        end
        retireReg(5'd5);
        @(negedge clk);                             // released right after writeback
        compareField("rsBlock", rsBlock, 0);
        compareField("outVld", outVld, 1);
        checkFields(refDecode(consumer, 1'b0), consumer);
        retireReg(5'd6);
        runDecode(32'h0010_0013, 1'b0);             // addi x0, x0, 1
        sendStrobe(32'h0000_0433, 1'b0);            // add x8, x0, x0
        @(negedge clk);
        compareField("rsBlock", rsBlock, 0);
        compareField("outVld", outVld, 1);
        checkFields(refDecode(32'h0000_0433, 1'b0), 32'h0000_0433);
        retireReg(5'd8);
    endtask

    task automatic flushCase();
        logic [31:0] w;
        w = {12'h123, 5'd3, 3'b000, 5'd9, 7'b0010011};                 // addi x9, x3, 0x123
        sendStrobe(w, 1'b0);
        flush = 1'b1;                               // in the output cycle
        @(negedge clk);
        compareField("outVld", outVld, 0);
        @(posedge clk);
        #1;
        flush = 1'b0;
        @(negedge clk);
        compareField("outVld", outVld, 0);
        runDecode(32'h0050_0293, 1'b0);             // addi x5, x0, 5
    endtask

    task automatic systemCases();
        logic [31:0] csrrw;
        csrrw = {12'h300, 5'd2, 3'b001, 5'd1, 7'b1110011};             // csrrw x1, mstatus, x2
        runDecode(32'h0000_0073, 1'b0);
        compareField("sysOp", sysOp, sysEcall);
        runDecode(32'h0010_0073, 1'b0);
        compareField("sysOp", sysOp, sysEbreak);
        runDecode(32'h3020_0073, 1'b0);
        compareField("sysOp", sysOp, sysMret);
        runDecode(csrrw, 1'b0);
        compareField("sysOp", sysOp, sysCsr);
        compareField("csrAddr", csrAddr, 12'h300);
    endtask

    initial begin
        rst = 1'b1;
        inVld = 1'b0;
        instr = 32'h0;
        pc = 64'h8000_0000;
        fetchErr = 1'b0;
        flush = 1'b0;
        wbVld = 1'b0;
        wbRd = 5'd0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        immediateCases();
        controlSweep();
        illegalCases();
        stallCase();
        flushCase();
        systemCases();
        $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/decodeTop_chk.sv */
`default_nettype none

module decodeTopChk (
    input logic clk,
    input logic rst,
    input logic inVld,
    input logic flush,
    input logic outVld,
    input logic rsBlock
);

    issueNotStalled: assert property (@(posedge clk) disable iff (rst) !(outVld && rsBlock))
        else $error("outVld and rsBlock high in the same cycle");

    // held slot is gone one cycle after flush
    quietAfterFlush: assert property (@(posedge clk) disable iff (rst) flush |=> !outVld)
        else $error("outVld high in the cycle after a flush");

    noStrobeInStall: assert property (@(posedge clk) disable iff (rst) rsBlock |-> !inVld)
        else $error("fetch strobe arrived while rsBlock was high");

endmodule

bind decodeTop decodeTopChk chk (
    .clk     (clk),
    .rst     (rst),
    .inVld   (inVld),
    .flush   (flush),
    .outVld  (outVld),
    .rsBlock (rsBlock)
);

`default_nettype wire
